// File: hw/gfx_pkg.sv
// Graphics controller package with widths, register layout and shared types
package gfx_pkg;

    localparam int reg_count = 8;

    typedef logic [2:0]  cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [8:0]  vpos_t;
    typedef logic [8:0]  hpos_t;
    typedef logic [17:0] rom_addr_t;
    typedef logic [15:0] rom_data_t;
    // Bank, layer flag, colour
    typedef logic [6:0]  pxl_color_t;
    typedef logic [3:0]  pxl_pal_t;

    // Register indices
    localparam cpu_addr_t reg_ctrl3 = 3'd3;
    localparam cpu_addr_t reg_pal   = 3'd6;
    localparam cpu_addr_t reg_irq   = 3'd7;

    // Control register 3 bits
    localparam int ctrl3_prio0_bit  = 2;
    localparam int ctrl3_layout_bit = 4;
    localparam int ctrl3_prio1_bit  = 5;
    localparam int ctrl3_narrow_bit = 6;

    // Palette register, bank field low bit
    localparam int pal_bank_lsb = 4;

    // Interrupt register bits
    localparam int irq_nmi_en_bit  = 0;
    localparam int irq_irq_en_bit  = 1;
    localparam int irq_firq_en_bit = 2;
    localparam int irq_flip_bit    = 3;
    localparam int irq_pace_bit    = 4;

    // Screen edges
    localparam vpos_t top_blank_lines = 9'd16;
    localparam hpos_t wide_left       = 9'd16;
    localparam hpos_t wide_right      = 9'd272;
    localparam hpos_t narrow_left     = 9'd24;
    localparam hpos_t narrow_right    = 9'd264;
    localparam hpos_t obj_left_cut    = 9'd40;
    localparam hpos_t obj_right_cut   = 9'd240;

    typedef struct packed {
        logic [1:0] prio_en;
        logic       layout;
        logic       narrow_en;
        logic       flip;
        logic [1:0] pal_bank;
        logic       nmi_en;
        logic       irq_en;
        logic       firq_en;
        logic       nmi_pace;
    } gfx_cfg_t;

    typedef struct packed {
        logic       scrwin;
        logic [7:0] color;
    } tile_pxl_t;

    typedef logic [7:0] obj_pxl_t;

    typedef struct packed {
        rom_addr_t addr;
    } rom_req_t;

    typedef enum logic [1:0] {
        idle,
        scroll,
        object
    } arb_state_t;

endpackage

// File: hw/gfx_regs.sv
// Configuration registers written by the CPU and decoded into the settings struct
`timescale 1ns/100ps

module gfx_regs #(
    parameter int regs_n = gfx_pkg::reg_count
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cs,
    input  logic                cpu_we,
    input  gfx_pkg::cpu_addr_t  cpu_addr,
    input  gfx_pkg::cpu_data_t  cpu_din,
    output gfx_pkg::gfx_cfg_t   cfg
);

    gfx_pkg::cpu_data_t regs [regs_n];
    logic               wr_en;

    assign wr_en = cpu_cs && cpu_we;

    // Write-only byte registers, all cleared on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < regs_n; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[cpu_addr] <= cpu_din;
        end
    end

    // Pull the named fields out of registers 3, 6 and 7
    always_comb begin
        cfg.prio_en[0] = regs[gfx_pkg::reg_ctrl3][gfx_pkg::ctrl3_prio0_bit];
        cfg.prio_en[1] = regs[gfx_pkg::reg_ctrl3][gfx_pkg::ctrl3_prio1_bit];
        cfg.layout     = regs[gfx_pkg::reg_ctrl3][gfx_pkg::ctrl3_layout_bit];
        cfg.narrow_en  = regs[gfx_pkg::reg_ctrl3][gfx_pkg::ctrl3_narrow_bit];

        cfg.pal_bank   = regs[gfx_pkg::reg_pal][gfx_pkg::pal_bank_lsb +: 2];

        cfg.nmi_en     = regs[gfx_pkg::reg_irq][gfx_pkg::irq_nmi_en_bit];
        cfg.irq_en     = regs[gfx_pkg::reg_irq][gfx_pkg::irq_irq_en_bit];
        cfg.firq_en    = regs[gfx_pkg::reg_irq][gfx_pkg::irq_firq_en_bit];
        cfg.flip       = regs[gfx_pkg::reg_irq][gfx_pkg::irq_flip_bit];
        cfg.nmi_pace   = regs[gfx_pkg::reg_irq][gfx_pkg::irq_pace_bit];
    end

endmodule

// File: hw/gfx_irq.sv
// Interrupt generator giving frame IRQ, line-paced NMI and half-rate FIRQ
`timescale 1ns/100ps

module gfx_irq (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic               lvbl,
    input  gfx_pkg::vpos_t     vdump,
    input  gfx_pkg::gfx_cfg_t  cfg,
    output logic               irqn,
    output logic               nmin,
    output logic               firqn
);

    logic last_lvbl;
    logic last_irqn;
    logic last_fast;
    logic last_slow;
    logic firq_tgl;
    logic last_tgl;
    logic nmi_edge;

    // Line 16 or line 32 cadence
    assign nmi_edge = cfg.nmi_pace ? (vdump[5] && !last_slow) : (vdump[4] && !last_fast);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irqn      <= 1'b1;
            nmin      <= 1'b1;
            firqn     <= 1'b1;
            last_lvbl <= 1'b0;
            last_irqn <= 1'b1;
            last_fast <= 1'b0;
            last_slow <= 1'b0;
            firq_tgl  <= 1'b1;
            last_tgl  <= 1'b1;
        end else if (pxl_cen) begin
            last_lvbl <= lvbl;
            last_irqn <= irqn;
            last_fast <= vdump[4];
            last_slow <= vdump[5];
            last_tgl  <= firq_tgl;

            // Once per frame, at the start of vertical blank
            if (!cfg.irq_en) begin
                irqn <= 1'b1;
            end else if (last_lvbl && !lvbl) begin
                irqn <= 1'b0;
            end

            if (!cfg.nmi_en) begin
                nmin <= 1'b1;
            end else if (nmi_edge) begin
                nmin <= 1'b0;
            end

            // Each IRQ acknowledge flips the toggle
            if (!last_irqn && irqn) begin
                firq_tgl <= ~firq_tgl;
            end

            if (!cfg.firq_en) begin
                firqn <= 1'b1;
            end else if (!last_tgl && firq_tgl) begin
                firqn <= 1'b0;
            end
        end
    end

    // Once acknowledged, IRQ stays released until the CPU enables it again
    irq_ack_holds: assert property (@(posedge clk) disable iff (rst)
        (pxl_cen && !cfg.irq_en) |=> (irqn until cfg.irq_en));

endmodule

// File: hw/gfx_rom_arb.sv
// Graphics ROM arbiter sharing one port between scroll and object requesters
`timescale 1ns/100ps

module gfx_rom_arb (
    input  logic                clk,
    input  logic                rst,
    input  logic                scr_req_valid,
    input  logic                obj_req_valid,
    input  gfx_pkg::rom_req_t   scr_req,
    input  gfx_pkg::rom_req_t   obj_req,
    output logic                scr_req_ready,
    output logic                obj_req_ready,
    output logic                scr_rsp_valid,
    output logic                obj_rsp_valid,
    output gfx_pkg::rom_data_t  rsp_data,
    output logic                rom_cs,
    output logic                rom_obj_sel,
    output gfx_pkg::rom_addr_t  rom_addr,
    input  gfx_pkg::rom_data_t  rom_data,
    input  logic                rom_ok
);

    gfx_pkg::arb_state_t state;
    logic                ok_wait;
    logic                scr_take;
    logic                obj_take;
    logic                rom_done;

    // Scroll layer wins when both ask at once
    assign scr_req_ready = (state == gfx_pkg::idle);
    assign obj_req_ready = (state == gfx_pkg::idle) && !scr_req_valid;

    assign scr_take = scr_req_valid && scr_req_ready;
    assign obj_take = obj_req_valid && obj_req_ready;
    assign rom_done = (state != gfx_pkg::idle) && rom_ok && ok_wait;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= gfx_pkg::idle;
            rom_cs        <= 1'b0;
            rom_obj_sel   <= 1'b0;
            ok_wait       <= 1'b0;
            scr_rsp_valid <= 1'b0;
            obj_rsp_valid <= 1'b0;
        end else begin
            scr_rsp_valid <= 1'b0;
            obj_rsp_valid <= 1'b0;
            case (state)
                gfx_pkg::idle: begin
                    ok_wait <= 1'b0;
                    if (scr_take) begin
                        state       <= gfx_pkg::scroll;
                        rom_cs      <= 1'b1;
                        rom_obj_sel <= 1'b0;
                    end else if (obj_take) begin
                        state       <= gfx_pkg::object;
                        rom_cs      <= 1'b1;
                        rom_obj_sel <= 1'b1;
                    end
                end
                default: begin
                    // rom_ok from the first cycle of rom_cs may be stale
                    if (rom_done) begin
                        state         <= gfx_pkg::idle;
                        rom_cs        <= 1'b0;
                        scr_rsp_valid <= (state == gfx_pkg::scroll);
                        obj_rsp_valid <= (state == gfx_pkg::object);
                    end else begin
                        ok_wait <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (scr_take) begin
            rom_addr <= scr_req.addr;
        end else if (obj_take) begin
            rom_addr <= obj_req.addr;
        end
        if (rom_done) begin
            rsp_data <= rom_data;
        end
    end

    rsp_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(scr_rsp_valid && obj_rsp_valid));

    cs_while_busy: assert property (@(posedge clk) disable iff (rst)
        (state != gfx_pkg::idle) |-> rom_cs);

endmodule

// File: hw/gfx_mixer.sv
// Pixel mixer choosing tile or object colour with borders and blanking
`timescale 1ns/100ps

module gfx_mixer #(
    parameter gfx_pkg::vpos_t top_blank_lines = gfx_pkg::top_blank_lines,
    parameter gfx_pkg::hpos_t wide_left       = gfx_pkg::wide_left,
    parameter gfx_pkg::hpos_t wide_right      = gfx_pkg::wide_right,
    parameter gfx_pkg::hpos_t narrow_left     = gfx_pkg::narrow_left,
    parameter gfx_pkg::hpos_t narrow_right    = gfx_pkg::narrow_right,
    parameter gfx_pkg::hpos_t obj_left_cut    = gfx_pkg::obj_left_cut,
    parameter gfx_pkg::hpos_t obj_right_cut   = gfx_pkg::obj_right_cut
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  gfx_pkg::gfx_cfg_t    cfg,
    input  gfx_pkg::hpos_t       hdump,
    input  gfx_pkg::vpos_t       vdump,
    input  gfx_pkg::tile_pxl_t   tile_pxl,
    input  gfx_pkg::obj_pxl_t    obj_pxl,
    output gfx_pkg::pxl_color_t  pxl_out,
    output gfx_pkg::pxl_pal_t    pxl_pal
);

    logic obj_blank;
    logic tile_blank;
    logic border_wide;
    logic border_narrow;
    logic blank_area;
    logic no_obj;
    logic tile_prio;
    logic tile_sel;

    assign obj_blank     = (obj_pxl[3:0] == 4'h0);
    assign tile_blank    = (tile_pxl.color[3:0] == 4'h0);
    assign border_wide   = (hdump < wide_left) || (hdump >= wide_right);
    assign border_narrow = cfg.narrow_en && ((hdump < narrow_left) || (hdump >= narrow_right));
    assign blank_area    = (vdump < top_blank_lines) || (!cfg.layout && (border_wide || border_narrow));

    // Wide layout hides objects under the fixed text columns
    assign no_obj = cfg.layout && (cfg.flip ? (hdump >= obj_right_cut) : (hdump < obj_left_cut));

    // prio_en[1] clear lets the scroll win even where its colour is zero
    assign tile_prio = cfg.prio_en[0] && tile_pxl.scrwin && (!cfg.prio_en[1] || !tile_blank);
    assign tile_sel  = obj_blank || no_obj || tile_prio;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_out <= '0;
            pxl_pal <= '0;
        end else if (pxl_cen) begin
            if (blank_area) begin
                pxl_out <= '0;
                pxl_pal <= '0;
            end else if (tile_sel) begin
                pxl_out <= {cfg.pal_bank, 1'b1, tile_pxl.color[3:0]};
                pxl_pal <= tile_pxl.color[7:4];
            end else begin
                pxl_out <= {cfg.pal_bank, 1'b0, obj_pxl[3:0]};
                pxl_pal <= obj_pxl[7:4];
            end
        end
    end

endmodule

// File: hw/gfx_top.sv
// Video controller top level joining registers, interrupts, ROM arbiter and mixer
`timescale 1ns/100ps

module gfx_top #(
    parameter int             regs_n          = gfx_pkg::reg_count,
    parameter gfx_pkg::vpos_t top_blank_lines = gfx_pkg::top_blank_lines,
    parameter gfx_pkg::hpos_t wide_left       = gfx_pkg::wide_left,
    parameter gfx_pkg::hpos_t wide_right      = gfx_pkg::wide_right,
    parameter gfx_pkg::hpos_t narrow_left     = gfx_pkg::narrow_left,
    parameter gfx_pkg::hpos_t narrow_right    = gfx_pkg::narrow_right,
    parameter gfx_pkg::hpos_t obj_left_cut    = gfx_pkg::obj_left_cut,
    parameter gfx_pkg::hpos_t obj_right_cut   = gfx_pkg::obj_right_cut
) (
    input  logic                 clk,
    input  logic                 rst,
    // CPU
    input  logic                 cpu_cs,
    input  logic                 cpu_we,
    input  gfx_pkg::cpu_addr_t   cpu_addr,
    input  gfx_pkg::cpu_data_t   cpu_din,
    output logic                 irqn,
    output logic                 nmin,
    output logic                 firqn,
    // ROM requesters
    input  logic                 scr_req_valid,
    output logic                 scr_req_ready,
    input  gfx_pkg::rom_req_t    scr_req,
    input  logic                 obj_req_valid,
    output logic                 obj_req_ready,
    input  gfx_pkg::rom_req_t    obj_req,
    output logic                 scr_rsp_valid,
    output logic                 obj_rsp_valid,
    output gfx_pkg::rom_data_t   rsp_data,
    // Graphics ROM
    output logic                 rom_cs,
    output logic                 rom_obj_sel,
    output gfx_pkg::rom_addr_t   rom_addr,
    input  gfx_pkg::rom_data_t   rom_data,
    input  logic                 rom_ok,
    // Video timing and pixels
    input  logic                 pxl_cen,
    input  logic                 lvbl,
    input  gfx_pkg::hpos_t       hdump,
    input  gfx_pkg::vpos_t       vdump,
    input  gfx_pkg::tile_pxl_t   tile_pxl,
    input  gfx_pkg::obj_pxl_t    obj_pxl,
    output gfx_pkg::pxl_color_t  pxl_out,
    output gfx_pkg::pxl_pal_t    pxl_pal,
    output logic                 flip
);

    gfx_pkg::gfx_cfg_t cfg;

    assign flip = cfg.flip;

    gfx_regs #(
        .regs_n (regs_n)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cfg      (cfg)
    );

    gfx_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lvbl    (lvbl),
        .vdump   (vdump),
        .cfg     (cfg),
        .irqn    (irqn),
        .nmin    (nmin),
        .firqn   (firqn)
    );

    gfx_rom_arb u_rom_arb (
        .clk           (clk),
        .rst           (rst),
        .scr_req_valid (scr_req_valid),
        .obj_req_valid (obj_req_valid),
        .scr_req       (scr_req),
        .obj_req       (obj_req),
        .scr_req_ready (scr_req_ready),
        .obj_req_ready (obj_req_ready),
        .scr_rsp_valid (scr_rsp_valid),
        .obj_rsp_valid (obj_rsp_valid),
        .rsp_data      (rsp_data),
        .rom_cs        (rom_cs),
        .rom_obj_sel   (rom_obj_sel),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .rom_ok        (rom_ok)
    );

    gfx_mixer #(
        .top_blank_lines (top_blank_lines),
        .wide_left       (wide_left),
        .wide_right      (wide_right),
        .narrow_left     (narrow_left),
        .narrow_right    (narrow_right),
        .obj_left_cut    (obj_left_cut),
        .obj_right_cut   (obj_right_cut)
    ) u_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .cfg      (cfg),
        .hdump    (hdump),
        .vdump    (vdump),
        .tile_pxl (tile_pxl),
        .obj_pxl  (obj_pxl),
        .pxl_out  (pxl_out),
        .pxl_pal  (pxl_pal)
    );

endmodule

// File: tests/gfx_tb.sv
// Testbench for the video controller driven by records from the test data file
`timescale 1ns/100ps

module gfx_tb;

    localparam int max_recs    = 64;
    localparam int cen_timeout = 64;
    localparam int rom_timeout = 200;

    logic                 clk;
    logic                 rst;
    logic                 cpu_cs;
    logic                 cpu_we;
    gfx_pkg::cpu_addr_t   cpu_addr;
    gfx_pkg::cpu_data_t   cpu_din;
    logic                 irqn;
    logic                 nmin;
    logic                 firqn;
    logic                 scr_req_valid;
    logic                 scr_req_ready;
    gfx_pkg::rom_req_t    scr_req;
    logic                 obj_req_valid;
    logic                 obj_req_ready;
    gfx_pkg::rom_req_t    obj_req;
    logic                 scr_rsp_valid;
    logic                 obj_rsp_valid;
    gfx_pkg::rom_data_t   rsp_data;
    logic                 rom_cs;
    logic                 rom_obj_sel;
    gfx_pkg::rom_addr_t   rom_addr;
    gfx_pkg::rom_data_t   rom_data = '0;
    logic                 rom_ok = 1'b0;
    logic                 pxl_cen;
    logic                 lvbl;
    gfx_pkg::hpos_t       hdump;
    gfx_pkg::vpos_t       vdump;
    gfx_pkg::tile_pxl_t   tile_pxl;
    gfx_pkg::obj_pxl_t    obj_pxl;
    gfx_pkg::pxl_color_t  pxl_out;
    gfx_pkg::pxl_pal_t    pxl_pal;
    logic                 flip;

    logic [63:0]          recs [max_recs];
    gfx_pkg::cpu_data_t   shadow [gfx_pkg::reg_count];
    logic [15:0]          lfsr;
    logic [1:0]           draw;
    logic [1:0]           rom_wait;
    logic                 rom_armed;

    gfx_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // ROM contents depend on every address bit
    function automatic gfx_pkg::rom_data_t rom_word(input gfx_pkg::rom_addr_t a);
        return {a[7:0], a[15:8]} ^ {14'h0, a[17:16]} ^ 16'h3c5a;
    endfunction

    // Graphics ROM with a random wait of 0 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            rom_ok    <= 1'b0;
            rom_armed <= 1'b0;
            rom_wait  <= '0;
            lfsr = 16'd8200;
        end else if (!rom_cs) begin
            rom_ok    <= 1'b0;
            rom_armed <= 1'b0;
        end else if (!rom_armed) begin
            for (int i = 0; i < 2; i++) begin
                lfsr = lfsr_step(lfsr);
                draw = {draw[0], lfsr[0]};
            end
            rom_armed <= 1'b1;
            rom_wait  <= draw;
        end else if (rom_wait == 2'd0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(rom_addr);
        end else begin
            rom_wait <= rom_wait - 2'd1;
        end
    end

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pxl(input string name, input gfx_pkg::pxl_color_t exp_out,
                             input gfx_pkg::pxl_pal_t exp_pal,
                             input gfx_pkg::pxl_color_t act_out,
                             input gfx_pkg::pxl_pal_t act_pal);
        if (exp_out !== act_out || exp_pal !== act_pal) begin
            report_error($sformatf("FAIL %s expected out %h pal %h actual out %h pal %h",
                                   name, exp_out, exp_pal, act_out, act_pal));
        end
    endtask

    // Lines packed as irqn, nmin, firqn
    task automatic check_irq(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            report_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_rom(input string name, input gfx_pkg::rom_data_t exp_data,
                             input logic exp_obj, input gfx_pkg::rom_data_t act_data,
                             input logic act_obj);
        if (exp_data !== act_data || exp_obj !== act_obj) begin
            report_error($sformatf("FAIL %s expected data %h obj %b actual data %h obj %b",
                                   name, exp_data, exp_obj, act_data, act_obj));
        end
    endtask

    task automatic check_flip(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            report_error($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // One pixel enable followed by a wait for settled outputs
    task automatic pulse_cen();
        @(posedge clk);
        pxl_cen <= 1'b1;
        @(posedge clk);
        pxl_cen <= 1'b0;
        @(negedge clk);
    endtask

    task automatic write_reg(input gfx_pkg::cpu_addr_t addr, input gfx_pkg::cpu_data_t data);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_we   <= 1'b1;
        cpu_addr <= addr;
        cpu_din  <= data;
        @(posedge clk);
        cpu_cs <= 1'b0;
        cpu_we <= 1'b0;
        shadow[addr] = data;
        // Flip output follows bit 3 of the interrupt register
        @(negedge clk);
        check_flip("flip after register write",
                   shadow[gfx_pkg::reg_irq][gfx_pkg::irq_flip_bit], flip);
    endtask

    task automatic set_irq_bit(input int bit_pos, input logic val);
        gfx_pkg::cpu_data_t v;
        v = shadow[gfx_pkg::reg_irq];
        v[bit_pos] = val;
        write_reg(gfx_pkg::reg_irq, v);
    endtask

    task automatic drive_pixel(input string name, input logic [63:0] rec);
        @(posedge clk);
        tile_pxl <= rec[56:48];
        obj_pxl  <= rec[47:40];
        hdump    <= rec[36:28];
        vdump    <= rec[24:16];
        pulse_cen();
        check_pxl(name, rec[14:8], rec[3:0], pxl_out, pxl_pal);
    endtask

    // Falling lvbl followed by a bounded wait for irqn
    task automatic fire_lvbl(input string name, input logic expect_fire);
        int n;
        @(posedge clk);
        lvbl <= 1'b1;
        pulse_cen();
        pulse_cen();
        @(posedge clk);
        lvbl <= 1'b0;
        n = 0;
        while (irqn && n < cen_timeout) begin
            pulse_cen();
            n++;
        end
        if (expect_fire && irqn) begin
            report_error($sformatf("timeout waiting for irqn to fall in %s", name));
        end
        check_irq(name, {!expect_fire, 1'b1, 1'b1}, {irqn, nmin, firqn});
        @(posedge clk);
        lvbl <= 1'b1;
    endtask

    task automatic ack_irq(input string name);
        set_irq_bit(gfx_pkg::irq_irq_en_bit, 1'b0);
        pulse_cen();
        check_irq({name, " ack"}, 3'b111, {irqn, nmin, firqn});
    endtask

    task automatic step_nmi_frame(input string name, input int first, input int last,
                                  input int interval, input int count);
        int seen;
        @(posedge clk);
        vdump <= '0;
        pulse_cen();
        seen = 0;
        for (int v = 1; v <= last; v++) begin
            @(posedge clk);
            vdump <= gfx_pkg::vpos_t'(v);
            pulse_cen();
            if (!nmin) begin
                check_count({name, " nmi line"}, first + seen * interval, v);
                seen++;
                set_irq_bit(gfx_pkg::irq_nmi_en_bit, 1'b0);
                pulse_cen();
                check_irq({name, " nmi ack"}, 3'b111, {irqn, nmin, firqn});
                set_irq_bit(gfx_pkg::irq_nmi_en_bit, 1'b1);
            end
        end
        check_count({name, " nmi count"}, count, seen);
    endtask

    task automatic count_firq(input string name, input int cycles, input int exp_falls);
        int falls;
        falls = 0;
        for (int c = 0; c < cycles; c++) begin
            fire_lvbl(name, 1'b1);
            ack_irq(name);
            set_irq_bit(gfx_pkg::irq_irq_en_bit, 1'b1);
            // Toggle moves two samples after the acknowledge
            for (int k = 0; k < 4; k++) begin
                pulse_cen();
                if (!firqn) begin
                    falls++;
                    set_irq_bit(gfx_pkg::irq_firq_en_bit, 1'b0);
                    pulse_cen();
                    set_irq_bit(gfx_pkg::irq_firq_en_bit, 1'b1);
                end
            end
        end
        check_count({name, " firq falls"}, exp_falls, falls);
    endtask

    task automatic serve_rom_pair(input string name, input gfx_pkg::rom_addr_t sa,
                                  input gfx_pkg::rom_addr_t oa, input logic first_obj);
        int   n;
        int   got;
        logic chan;
        logic take_scr;
        logic take_obj;
        @(posedge clk);
        scr_req_valid <= 1'b1;
        scr_req.addr  <= sa;
        obj_req_valid <= 1'b1;
        obj_req.addr  <= oa;
        got = 0;
        n = 0;
        while (got < 2 && n < rom_timeout) begin
            @(negedge clk);
            n++;
            if (scr_rsp_valid || obj_rsp_valid) begin
                chan = (got == 0) ? first_obj : !first_obj;
                check_rom($sformatf("%s response %0d", name, got), rom_word(chan ? oa : sa),
                          chan, rsp_data, obj_rsp_valid);
                check_rom($sformatf("%s select %0d", name, got), rom_word(chan ? oa : sa),
                          chan, rsp_data, rom_obj_sel);
                got++;
            end
            take_scr = scr_req_valid && scr_req_ready;
            take_obj = obj_req_valid && obj_req_ready;
            @(posedge clk);
            if (take_scr) begin
                scr_req_valid <= 1'b0;
            end
            if (take_obj) begin
                obj_req_valid <= 1'b0;
            end
        end
        if (got < 2) begin
            report_error($sformatf("timeout waiting for ROM responses in %s", name));
        end
    endtask

    initial begin
        int          i;
        logic [63:0] rec;
        string       name;
        rst           = 1'b1;
        cpu_cs        = 1'b0;
        cpu_we        = 1'b0;
        cpu_addr      = '0;
        cpu_din       = '0;
        scr_req_valid = 1'b0;
        scr_req       = '0;
        obj_req_valid = 1'b0;
        obj_req       = '0;
        pxl_cen       = 1'b0;
        lvbl          = 1'b1;
        hdump         = '0;
        vdump         = '0;
        tile_pxl      = '0;
        obj_pxl       = '0;
        for (int r = 0; r < gfx_pkg::reg_count; r++) begin
            shadow[r] = '0;
        end
        $readmemh("tests/gfx_tests.hex", recs);
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        i = 0;
        while (i < max_recs && recs[i][63:60] != 4'h0) begin
            rec = recs[i];
            name = $sformatf("record %0d", i);
            case (rec[63:60])
                4'h1: write_reg(rec[50:48], rec[47:40]);
                4'h2: drive_pixel({"pixel ", name}, rec);
                4'h3: begin
                    fire_lvbl({"irq ", name}, rec[40]);
                    if (rec[40]) begin
                        ack_irq({"irq ", name});
                    end
                end
                4'h4: step_nmi_frame(name, rec[39:28], rec[27:16], rec[15:8], rec[7:0]);
                4'h5: count_firq(name, rec[39:28], rec[7:0]);
                4'h6: serve_rom_pair({"rom ", name}, rec[57:40], rec[33:16], rec[8]);
                default: report_error($sformatf("unknown opcode in %s", name));
            endcase
            i++;
        end

        if (i == 0) begin
            report_error("no test records were read");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: tests/gfx_tests.hex
// op_a_b_c_d_e_f  1 reg write (a addr, b data)  2 pixel (a tile, b obj, c hdump, d vdump,
// e pxl_out, f pxl_pal)  3 irq (b fires)  4 nmi (c first, d last line, e interval, f count)
// 5 firq (c cycles, f falls)  6 rom (ab scroll addr, cd object addr, e first obj)  0 end
1_006_20_000_000_00_00
1_003_04_000_000_00_00
2_037_a0_080_040_57_03
2_037_a5_080_040_45_0a
2_130_a5_080_040_50_03
1_003_24_000_000_00_00
2_130_a5_080_040_45_0a
2_13c_a5_080_040_5c_03
2_03c_b6_080_040_46_0b
2_13c_a5_080_00f_00_00
2_13c_a5_080_010_5c_03
2_13c_a5_00f_040_00_00
2_13c_a5_010_040_5c_03
2_13c_a5_110_040_00_00
2_13c_a5_10f_040_5c_03
1_003_64_000_000_00_00
2_13c_a5_010_040_00_00
2_13c_a5_018_040_5c_03
2_13c_a5_108_040_00_00
1_003_14_000_000_00_00
2_03c_a5_027_040_5c_03
2_03c_a5_028_040_45_0a
2_03c_a5_008_040_5c_03
2_03c_a5_0f0_040_45_0a
1_007_08_000_000_00_00
2_03c_a5_0f0_040_5c_03
2_03c_a5_0ef_040_45_0a
2_03c_a5_020_040_45_0a
1_007_02_000_000_00_00
3_000_01_000_000_00_00
3_000_00_000_000_00_00
1_007_01_000_000_00_00
4_000_00_010_0ff_20_08
1_007_11_000_000_00_00
4_000_00_020_0ff_40_04
1_007_06_000_000_00_00
5_000_00_004_000_00_02
1_007_00_000_000_00_00
6_123_45_03a_bcd_00_00
6_3ff_ff_000_001_00_00
0_000_00_000_000_00_00

// File: project.f
hw/gfx_pkg.sv
hw/gfx_regs.sv
hw/gfx_irq.sv
hw/gfx_rom_arb.sv
hw/gfx_mixer.sv
hw/gfx_top.sv
tests/gfx_tb.sv
